// File: source/tlb_entry_pkg.sv
// tlb entry package: storage format of one TLB entry and the write/invalidate command
package tlb_entry_pkg;

    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = $clog2(tlb_num);

    // page sizes accepted on write, anything else becomes 4 KB
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_2m = 6'd21;

    // one half of an even/odd pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [9:0]  asid;
        logic [5:0]  ps;
        logic        g;
        logic        e;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        inv_all,
        inv_asid_nonglobal,
        inv_asid_va
    } inv_op_t;

    // write and invalidate strobes, never both in one cycle
    typedef struct packed {
        logic                 we;
        logic [tlb_idx_w-1:0] widx;
        tlb_entry_t           wentry;
        logic                 inv;
        inv_op_t              inv_op;
        logic [9:0]           inv_asid;
        logic [31:0]          inv_va;
    } tlb_cmd_t;

endpackage

// File: source/xlate_pkg.sv
// translation package: request, response, configuration and stage-to-stage types
package xlate_pkg;

    typedef enum logic [1:0] {
        acc_load  = 2'd0,
        acc_store = 2'd1,
        acc_fetch = 2'd2
    } access_t;

    typedef enum logic [2:0] {
        ex_none,
        ex_tlbr,
        ex_pil,
        ex_pis,
        ex_pif,
        ex_ppi,
        ex_pme
    } excp_t;

    // one direct-mapped window
    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic       da;
        logic [1:0] da_mat;
        logic [9:0] asid;
        logic [1:0] plv;
        dmw_cfg_t   dmw0;
        dmw_cfg_t   dmw1;
    } xlate_cfg_t;

    typedef struct packed {
        logic [31:0] vaddr;
        access_t     access;
    } xlate_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic [1:0]  mat;
        excp_t       excp;
    } xlate_rsp_t;

    // everything the resolve stage needs from the lookup stage
    typedef struct packed {
        logic [31:0]              vaddr;
        access_t                  access;
        logic [1:0]               plv;
        logic                     da;
        logic [1:0]               da_mat;
        logic                     dmw_hit;
        logic [1:0]               dmw_mat;
        logic [2:0]               dmw_pseg;
        logic                     tlb_hit;
        logic [5:0]               ps;
        tlb_entry_pkg::tlb_page_t page;
    } lookup_q_t;

endpackage

// File: source/tlb_array.sv
// tlb array: sixteen fully associative entries with write, invalidate and one match port
`timescale 1ns/1ps

module tlb_array (
    input  logic                      clk,
    input  logic                      reset,
    input  tlb_entry_pkg::tlb_cmd_t   cmd,
    input  logic [18:0]               look_vpn2,
    input  logic [9:0]                look_asid,
    output logic                      hit,
    output logic [5:0]                hit_ps,
    output tlb_entry_pkg::tlb_page_t  hit_page0,
    output tlb_entry_pkg::tlb_page_t  hit_page1
);

    tlb_entry_pkg::tlb_entry_t entries [tlb_entry_pkg::tlb_num];
    tlb_entry_pkg::tlb_entry_t wr_entry;

    logic [tlb_entry_pkg::tlb_num-1:0]   match;
    logic [tlb_entry_pkg::tlb_num-1:0]   inv_hit;
    logic [tlb_entry_pkg::tlb_idx_w-1:0] sel;

    // a pair spans twice the page size, so bit ps selects the half
    function automatic logic vpn_match(tlb_entry_pkg::tlb_entry_t ent, logic [18:0] vpn2);
        if (ent.ps == tlb_entry_pkg::ps_2m) begin
            return ent.vpn2[18:9] == vpn2[18:9];
        end
        return ent.vpn2 == vpn2;
    endfunction

    // odd sizes fall back to 4 KB
    always_comb begin
        wr_entry = cmd.wentry;
        if (cmd.wentry.ps != tlb_entry_pkg::ps_2m) begin
            wr_entry.ps = tlb_entry_pkg::ps_4k;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_entry_pkg::tlb_num; i++) begin
            match[i] = entries[i].e && (entries[i].g || entries[i].asid == look_asid)
                       && vpn_match(entries[i], look_vpn2);
            case (cmd.inv_op)
                tlb_entry_pkg::inv_all:
                    inv_hit[i] = 1'b1;
                tlb_entry_pkg::inv_asid_nonglobal:
                    inv_hit[i] = !entries[i].g && entries[i].asid == cmd.inv_asid;
                tlb_entry_pkg::inv_asid_va:
                    inv_hit[i] = (entries[i].g || entries[i].asid == cmd.inv_asid)
                                 && vpn_match(entries[i], cmd.inv_va[31:13]);
                default:
                    inv_hit[i] = 1'b0;
            endcase
        end
    end

    // lowest index wins
    always_comb begin
        sel = '0;
        for (int i = tlb_entry_pkg::tlb_num - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel = i[tlb_entry_pkg::tlb_idx_w-1:0];
            end
        end
    end

    assign hit       = |match;
    assign hit_ps    = entries[sel].ps;
    assign hit_page0 = entries[sel].page0;
    assign hit_page1 = entries[sel].page1;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entry_pkg::tlb_num; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (cmd.we) begin
            entries[cmd.widx] <= wr_entry;
        end else if (cmd.inv) begin
            for (int i = 0; i < tlb_entry_pkg::tlb_num; i++) begin
                if (inv_hit[i]) begin
                    entries[i].e <= 1'b0;
                end
            end
        end
    end

endmodule

// File: source/xlate_lookup.sv
// lookup stage: window check and TLB match, registers the chosen page for the resolve stage
`timescale 1ns/1ps

module xlate_lookup (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  xlate_pkg::xlate_req_t     req,
    input  xlate_pkg::xlate_cfg_t     cfg,
    output logic [18:0]               look_vpn2,
    output logic [9:0]                look_asid,
    input  logic                      hit,
    input  logic [5:0]                hit_ps,
    input  tlb_entry_pkg::tlb_page_t  hit_page0,
    input  tlb_entry_pkg::tlb_page_t  hit_page1,
    output logic                      q_valid,
    input  logic                      q_ready,
    output xlate_pkg::lookup_q_t      q
);

    xlate_pkg::lookup_q_t q_next;
    logic                 dmw0_hit;
    logic                 dmw1_hit;
    logic                 odd;

    // window hits on segment match at an allowed level
    function automatic logic win_hit(xlate_pkg::dmw_cfg_t dmw, logic [2:0] seg,
                                     logic [1:0] plv);
        return dmw.vseg == seg && ((plv == 2'd0 && dmw.plv0) || (plv == 2'd3 && dmw.plv3));
    endfunction

    assign look_vpn2 = req.vaddr[31:13];
    assign look_asid = cfg.asid;

    assign dmw0_hit = win_hit(cfg.dmw0, req.vaddr[31:29], cfg.plv);
    assign dmw1_hit = win_hit(cfg.dmw1, req.vaddr[31:29], cfg.plv);

    // pair half select
    assign odd = (hit_ps == tlb_entry_pkg::ps_2m) ? req.vaddr[21] : req.vaddr[12];

    always_comb begin
        q_next.vaddr    = req.vaddr;
        q_next.access   = req.access;
        q_next.plv      = cfg.plv;
        q_next.da       = cfg.da;
        q_next.da_mat   = cfg.da_mat;
        // window 0 first
        q_next.dmw_hit  = dmw0_hit || dmw1_hit;
        q_next.dmw_mat  = dmw0_hit ? cfg.dmw0.mat : cfg.dmw1.mat;
        q_next.dmw_pseg = dmw0_hit ? cfg.dmw0.pseg : cfg.dmw1.pseg;
        q_next.tlb_hit  = hit;
        q_next.ps       = hit_ps;
        q_next.page     = odd ? hit_page1 : hit_page0;
    end

    assign req_ready = !q_valid || q_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            q_valid <= 1'b0;
        end else if (req_ready) begin
            q_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            q <= q_next;
        end
    end

endmodule

// File: source/xlate_resolve.sv
// resolve stage: physical address, memory type and exception from the lookup result
`timescale 1ns/1ps

module xlate_resolve (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  q_valid,
    output logic                  q_ready,
    input  xlate_pkg::lookup_q_t  q,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output xlate_pkg::xlate_rsp_t rsp
);

    xlate_pkg::xlate_rsp_t rsp_next;

    always_comb begin
        rsp_next.excp = xlate_pkg::ex_none;
        if (q.da) begin
            rsp_next.paddr = q.vaddr;
            rsp_next.mat   = q.da_mat;
        end else if (q.dmw_hit) begin
            rsp_next.paddr = {q.dmw_pseg, q.vaddr[28:0]};
            rsp_next.mat   = q.dmw_mat;
        end else begin
            // 2 MB drops the low pfn bits
            if (q.ps == tlb_entry_pkg::ps_2m) begin
                rsp_next.paddr = {q.page.pfn[19:9], q.vaddr[20:0]};
            end else begin
                rsp_next.paddr = {q.page.pfn, q.vaddr[11:0]};
            end
            rsp_next.mat = q.page.mat;
            // priority: refill, invalid, privilege, modify
            if (!q.tlb_hit) begin
                rsp_next.excp = xlate_pkg::ex_tlbr;
            end else if (!q.page.v) begin
                case (q.access)
                    xlate_pkg::acc_fetch: rsp_next.excp = xlate_pkg::ex_pif;
                    xlate_pkg::acc_store: rsp_next.excp = xlate_pkg::ex_pis;
                    default:              rsp_next.excp = xlate_pkg::ex_pil;
                endcase
            end else if (q.plv > q.page.plv) begin
                rsp_next.excp = xlate_pkg::ex_ppi;
            end else if (q.access == xlate_pkg::acc_store && !q.page.d) begin
                rsp_next.excp = xlate_pkg::ex_pme;
            end
        end
    end

    assign q_ready = !rsp_valid || rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (q_ready) begin
            rsp_valid <= q_valid;
        end
    end

    // response holds while stalled
    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            rsp <= rsp_next;
        end
    end

endmodule

// File: source/mmu_top.sv
// mmu top: TLB array with the two-stage translation pipeline
`timescale 1ns/1ps

module mmu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  xlate_pkg::xlate_req_t   req,
    input  xlate_pkg::xlate_cfg_t   cfg,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output xlate_pkg::xlate_rsp_t   rsp,
    input  tlb_entry_pkg::tlb_cmd_t cmd
);

    logic [18:0]              look_vpn2;
    logic [9:0]               look_asid;
    logic                     hit;
    logic [5:0]               hit_ps;
    tlb_entry_pkg::tlb_page_t hit_page0;
    tlb_entry_pkg::tlb_page_t hit_page1;
    logic                     q_valid;
    logic                     q_ready;
    xlate_pkg::lookup_q_t     q;

    tlb_array u_tlb (
        .clk(clk), .reset(reset), .cmd(cmd),
        .look_vpn2(look_vpn2), .look_asid(look_asid),
        .hit(hit), .hit_ps(hit_ps), .hit_page0(hit_page0), .hit_page1(hit_page1)
    );

    xlate_lookup u_lookup (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req(req), .cfg(cfg),
        .look_vpn2(look_vpn2), .look_asid(look_asid),
        .hit(hit), .hit_ps(hit_ps), .hit_page0(hit_page0), .hit_page1(hit_page1),
        .q_valid(q_valid), .q_ready(q_ready), .q(q)
    );

    xlate_resolve u_resolve (
        .clk(clk), .reset(reset), .q_valid(q_valid), .q_ready(q_ready), .q(q),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

endmodule

// File: verif/mmu_sva.sv
// response assertions: reset state, stall stability and legal exception codes
`timescale 1ns/1ps

module mmu_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  rsp_valid,
    input logic                  rsp_ready,
    input xlate_pkg::xlate_rsp_t rsp
);

    assert property (@(posedge clk) reset |=> !rsp_valid)
        else $error("rsp_valid high in the cycle after reset");

    // stalled response keeps valid and data
    assert property (@(posedge clk) disable iff (reset)
                     rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
                     rsp_valid |-> rsp.excp <= xlate_pkg::ex_pme)
        else $error("illegal exception code on rsp");

endmodule

// File: verif/mmu_checker.sv
// response checker: compares each accepted response with the expected queue and counts results
`timescale 1ns/1ps

module mmu_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  rsp_valid,
    input logic                  rsp_ready,
    input xlate_pkg::xlate_rsp_t rsp
);

    xlate_pkg::xlate_rsp_t exp_q[$];
    int pass_cnt = 0;
    int fail_cnt = 0;

    function automatic void push_expected(xlate_pkg::xlate_rsp_t e);
        exp_q.push_back(e);
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_rsp();
        xlate_pkg::xlate_rsp_t e;
        logic bad;
        bad = 1'b0;
        if (exp_q.size() == 0) begin
            $display("response %0d arrived with no request outstanding", pass_cnt + fail_cnt + 1);
            fail_cnt++;
            return;
        end
        e = exp_q.pop_front();
        if (rsp.excp !== e.excp) begin
            $display("** Error: rsp.excp expected %h got %h", e.excp, rsp.excp);
            bad = 1'b1;
        end
        // address and type only matter without an exception
        if (e.excp == xlate_pkg::ex_none && rsp.paddr !== e.paddr) begin
            $display("** Error: rsp.paddr expected %h got %h", e.paddr, rsp.paddr);
            bad = 1'b1;
        end
        if (e.excp == xlate_pkg::ex_none && rsp.mat !== e.mat) begin
            $display("** Error: rsp.mat expected %h got %h", e.mat, rsp.mat);
            bad = 1'b1;
        end
        if (bad) begin
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        $display("response %0d: %s paddr %h mat %h excp %h", pass_cnt + fail_cnt,
                 bad ? "mismatch" : "ok", rsp.paddr, rsp.mat, rsp.excp);
    endtask

    always @(posedge clk) begin
        if (!reset && rsp_valid && rsp_ready) begin
            check_rsp();
        end
    end

endmodule

// File: verif/mmu_tb.sv
// mmu testbench: table-driven translations with random response back-pressure
`timescale 1ns/1ps

module mmu_tb;

    // one table row, either a TLB command or a request with its expected response
    typedef struct packed {
        logic                    is_cmd;
        tlb_entry_pkg::tlb_cmd_t cmd;
        xlate_pkg::xlate_cfg_t   cfg;
        xlate_pkg::xlate_req_t   req;
        xlate_pkg::xlate_rsp_t   exp;
    } row_t;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    req_valid;
    logic                    req_ready;
    xlate_pkg::xlate_req_t   req;
    xlate_pkg::xlate_cfg_t   cfg;
    logic                    rsp_valid;
    logic                    rsp_ready;
    xlate_pkg::xlate_rsp_t   rsp;
    tlb_entry_pkg::tlb_cmd_t cmd;

    logic [31:0] lfsr = 32'h26cff8b6;
    row_t        rows[$];
    int          n_req = 0;
    xlate_pkg::xlate_cfg_t da_cfg, k0_a5, u3_a5, k0_a6;

    always #20 clk = ~clk;

    mmu_top UUT (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .cfg(cfg), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp), .cmd(cmd)
    );

    mmu_checker chk (
        .clk(clk), .reset(reset), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

    bind xlate_resolve mmu_sva u_sva (
        .clk(clk), .reset(reset), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(negedge clk) begin
        lfsr = lfsr_step(lfsr);
        rsp_ready = lfsr[0];
    end

    function automatic xlate_pkg::xlate_cfg_t make_cfg(logic da, logic [1:0] plv,
                                                       logic [9:0] asid);
        xlate_pkg::xlate_cfg_t c;
        c.da     = da;
        c.da_mat = 2'h3;
        c.asid   = asid;
        c.plv    = plv;
        // window 0 kernel only, window 1 both levels
        c.dmw0   = '{plv0: 1'b1, plv3: 1'b0, mat: 2'h1, vseg: 3'h4, pseg: 3'h0};
        c.dmw1   = '{plv0: 1'b1, plv3: 1'b1, mat: 2'h0, vseg: 3'h5, pseg: 3'h1};
        return c;
    endfunction

    function automatic tlb_entry_pkg::tlb_page_t make_page(logic [19:0] pfn, logic [1:0] mat,
                                                           logic [1:0] plv, logic d, logic v);
        return '{pfn: pfn, mat: mat, plv: plv, d: d, v: v};
    endfunction

    function automatic void add_write(logic [3:0] idx, logic [31:0] va, logic [9:0] asid,
                                      logic [5:0] ps, logic g, tlb_entry_pkg::tlb_page_t p0,
                                      tlb_entry_pkg::tlb_page_t p1);
        row_t r;
        r = '0;
        r.is_cmd     = 1'b1;
        r.cmd.we     = 1'b1;
        r.cmd.widx   = idx;
        r.cmd.wentry = '{vpn2: va[31:13], asid: asid, ps: ps, g: g, e: 1'b1,
                         page0: p0, page1: p1};
        rows.push_back(r);
    endfunction

    function automatic void add_inv(tlb_entry_pkg::inv_op_t op, logic [9:0] asid,
                                    logic [31:0] va);
        row_t r;
        r = '0;
        r.is_cmd       = 1'b1;
        r.cmd.inv      = 1'b1;
        r.cmd.inv_op   = op;
        r.cmd.inv_asid = asid;
        r.cmd.inv_va   = va;
        rows.push_back(r);
    endfunction

    function automatic void add_req(xlate_pkg::xlate_cfg_t c, logic [31:0] va,
                                    xlate_pkg::access_t acc, logic [31:0] pa, logic [1:0] mat,
                                    xlate_pkg::excp_t ex);
        row_t r;
        r = '0;
        r.cfg        = c;
        r.req.vaddr  = va;
        r.req.access = acc;
        r.exp.paddr  = pa;
        r.exp.mat    = mat;
        r.exp.excp   = ex;
        rows.push_back(r);
        n_req++;
    endfunction

    function automatic void add_ok(xlate_pkg::xlate_cfg_t c, logic [31:0] va,
                                   xlate_pkg::access_t acc, logic [31:0] pa, logic [1:0] mat);
        add_req(c, va, acc, pa, mat, xlate_pkg::ex_none);
    endfunction

    function automatic void add_excp(xlate_pkg::xlate_cfg_t c, logic [31:0] va,
                                     xlate_pkg::access_t acc, xlate_pkg::excp_t ex);
        add_req(c, va, acc, 32'h0, 2'h0, ex);
    endfunction

    function automatic void build_rows();
        // direct address mode
        add_ok(da_cfg, 32'h1234_5678, xlate_pkg::acc_load, 32'h1234_5678, 2'h3);
        add_ok(da_cfg, 32'h8000_0040, xlate_pkg::acc_store, 32'h8000_0040, 2'h3);
        add_ok(da_cfg, 32'hfedc_ba98, xlate_pkg::acc_fetch, 32'hfedc_ba98, 2'h3);
        // windows, then window 0 refused at level 3 on an empty TLB
        add_ok(k0_a5, 32'h8000_1234, xlate_pkg::acc_load, 32'h0000_1234, 2'h1);
        add_ok(u3_a5, 32'ha012_3456, xlate_pkg::acc_fetch, 32'h2012_3456, 2'h0);
        add_excp(u3_a5, 32'h8000_1234, xlate_pkg::acc_load, xlate_pkg::ex_tlbr);
        add_write(4'd2, 32'h0040_0000, 10'h5, tlb_entry_pkg::ps_4k, 1'b0,
                  make_page(20'h12345, 2'h1, 2'h3, 1'b1, 1'b1),
                  make_page(20'h54321, 2'h2, 2'h3, 1'b0, 1'b1));
        add_write(4'd7, 32'h0400_0000, 10'h5, tlb_entry_pkg::ps_2m, 1'b1,
                  make_page(20'h80000, 2'h1, 2'h0, 1'b1, 1'b1),
                  make_page(20'h80200, 2'h2, 2'h3, 1'b1, 1'b1));
        add_write(4'd0, 32'h0080_0000, 10'h5, tlb_entry_pkg::ps_4k, 1'b0,
                  make_page(20'h00000, 2'h0, 2'h3, 1'b0, 1'b0),
                  make_page(20'h0abcd, 2'h1, 2'h3, 1'b1, 1'b1));
        add_write(4'd9, 32'h0100_0000, 10'h6, tlb_entry_pkg::ps_4k, 1'b0,
                  make_page(20'h11111, 2'h1, 2'h3, 1'b1, 1'b1),
                  make_page(20'h22222, 2'h2, 2'h3, 1'b1, 1'b1));
        // both halves of the 4 KB and 2 MB pairs
        add_ok(k0_a5, 32'h0040_0abc, xlate_pkg::acc_load, 32'h1234_5abc, 2'h1);
        add_ok(k0_a5, 32'h0040_1def, xlate_pkg::acc_load, 32'h5432_1def, 2'h2);
        add_ok(k0_a5, 32'h0412_3456, xlate_pkg::acc_fetch, 32'h8012_3456, 2'h1);
        add_ok(k0_a6, 32'h0434_5678, xlate_pkg::acc_load, 32'h8034_5678, 2'h2);
        add_excp(k0_a6, 32'h0040_0abc, xlate_pkg::acc_load, xlate_pkg::ex_tlbr);
        add_excp(k0_a5, 32'h0080_0010, xlate_pkg::acc_load, xlate_pkg::ex_pil);
        add_excp(k0_a5, 32'h0080_0010, xlate_pkg::acc_store, xlate_pkg::ex_pis);
        add_excp(k0_a5, 32'h0080_0010, xlate_pkg::acc_fetch, xlate_pkg::ex_pif);
        add_excp(u3_a5, 32'h0412_3456, xlate_pkg::acc_load, xlate_pkg::ex_ppi);
        add_excp(k0_a5, 32'h0040_1def, xlate_pkg::acc_store, xlate_pkg::ex_pme);
        add_ok(u3_a5, 32'h0040_1234, xlate_pkg::acc_load, 32'h5432_1234, 2'h2);
        add_ok(k0_a5, 32'h0040_0100, xlate_pkg::acc_store, 32'h1234_5100, 2'h1);
        add_ok(k0_a5, 32'h0080_1020, xlate_pkg::acc_load, 32'h0abc_d020, 2'h1);
        add_ok(k0_a6, 32'h0100_0044, xlate_pkg::acc_load, 32'h1111_1044, 2'h1);
        // invalidate modes, narrowest first
        add_inv(tlb_entry_pkg::inv_asid_va, 10'h5, 32'h0080_0000);
        add_excp(k0_a5, 32'h0080_1020, xlate_pkg::acc_load, xlate_pkg::ex_tlbr);
        add_ok(k0_a5, 32'h0040_0abc, xlate_pkg::acc_load, 32'h1234_5abc, 2'h1);
        add_inv(tlb_entry_pkg::inv_asid_nonglobal, 10'h5, 32'h0);
        add_excp(k0_a5, 32'h0040_0abc, xlate_pkg::acc_load, xlate_pkg::ex_tlbr);
        add_ok(k0_a6, 32'h0100_0044, xlate_pkg::acc_load, 32'h1111_1044, 2'h1);
        add_ok(k0_a5, 32'h0412_3456, xlate_pkg::acc_load, 32'h8012_3456, 2'h1);
        // global entry goes under a foreign asid, the asid 6 entry stays
        add_inv(tlb_entry_pkg::inv_asid_va, 10'h6, 32'h0400_0000);
        add_excp(k0_a5, 32'h0412_3456, xlate_pkg::acc_load, xlate_pkg::ex_tlbr);
        add_ok(k0_a6, 32'h0100_0044, xlate_pkg::acc_load, 32'h1111_1044, 2'h1);
        add_inv(tlb_entry_pkg::inv_all, 10'h0, 32'h0);
        add_excp(k0_a6, 32'h0100_0044, xlate_pkg::acc_load, xlate_pkg::ex_tlbr);
        add_excp(k0_a5, 32'h0412_3456, xlate_pkg::acc_load, xlate_pkg::ex_tlbr);
        add_ok(k0_a5, 32'h8000_1234, xlate_pkg::acc_load, 32'h0000_1234, 2'h1);
    endfunction

    initial begin
        row_t r;
        int   waited;
        logic timed_out;
        timed_out = 1'b0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        cfg       = '0;
        cmd       = '0;
        rsp_ready = 1'b0;
        da_cfg    = make_cfg(1'b1, 2'd0, 10'h5);
        k0_a5     = make_cfg(1'b0, 2'd0, 10'h5);
        u3_a5     = make_cfg(1'b0, 2'd3, 10'h5);
        k0_a6     = make_cfg(1'b0, 2'd0, 10'h6);
        build_rows();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            if (timed_out) begin
                break;
            end
            @(negedge clk);
            r = rows[i];
            // request rows carry an all-zero command
            cmd       = r.cmd;
            req_valid = !r.is_cmd;
            req       = r.req;
            cfg       = r.cfg;
            if (!r.is_cmd) begin
                waited = 0;
                @(posedge clk);
                while (!req_ready && waited < 200) begin
                    waited++;
                    @(posedge clk);
                end
                if (req_ready) begin
                    chk.push_expected(r.exp);
                end else begin
                    $display("timeout: request in row %0d was never accepted", i);
                    timed_out = 1'b1;
                end
            end
        end

        @(negedge clk);
        req_valid = 1'b0;
        cmd       = '0;
        waited    = 0;
        while (!timed_out && chk.pending() != 0 && waited < 200) begin
            waited++;
            @(negedge clk);
        end
        if (!timed_out && chk.pending() != 0) begin
            $display("timeout: %0d responses never arrived", chk.pending());
            timed_out = 1'b1;
        end

        $display("%0d requests, %0d passed, %0d failed", n_req, chk.pass_cnt, chk.fail_cnt);
        if (!timed_out && chk.fail_cnt == 0 && chk.pass_cnt == n_req) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: flist.f
source/tlb_entry_pkg.sv
source/xlate_pkg.sv
source/tlb_array.sv
source/xlate_lookup.sv
source/xlate_resolve.sv
source/mmu_top.sv
verif/mmu_sva.sv
verif/mmu_checker.sv
verif/mmu_tb.sv

// File: Makefile
BIN  := obj_dir/Vmmu_tb
SRCS := $(shell grep -v '^+' flist.f)

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module mmu_tb -f flist.f

run: $(BIN)
	$(BIN) > sim.log 2>&1 || true
	@cat sim.log
	@! grep -q "Simulation failed" sim.log
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
